// ==== logic/cluster_defs.svh ====
/*
 * Cluster DCR path definitions
 * Bus widths, the address window of each target and the target codes.
 */

`ifndef CLUSTER_DEFS_SVH
`define CLUSTER_DEFS_SVH

//**************************************************************************
// Bus widths
//**************************************************************************

`define DCR_ADDR_BITS       12
`define DCR_DATA_BITS       32
`define DCR_IDX_BITS        3
`define DCR_TGT_BITS        2

// Saturating count of writes that hit no window
`define DROP_CNT_BITS       16

//**************************************************************************
// Address windows, END is exclusive
//**************************************************************************

`define DCR_BASE_BEGIN      12'h001
`define DCR_BASE_END        12'h009

`define DCR_RASTER_BEGIN    12'h010
`define DCR_RASTER_END      12'h014

`define DCR_TEX_BEGIN       12'h020
`define DCR_TEX_END         12'h024

// Target codes used by the read port
`define DCR_TGT_BASE        0
`define DCR_TGT_RASTER      1
`define DCR_TGT_TEX         2

`endif

// ==== logic/cluster_pkg.sv ====
/*
 * Cluster DCR package
 * Width types and the packed structs carried along the DCR write path
 * and the register read port.
 */

`default_nettype none

`include "cluster_defs.svh"

package cluster_pkg;

    typedef logic [`DCR_ADDR_BITS-1:0] dcr_addr_t;
    typedef logic [`DCR_DATA_BITS-1:0] dcr_data_t;
    typedef logic [`DCR_IDX_BITS-1:0]  dcr_idx_t;
    typedef logic [`DCR_TGT_BITS-1:0]  dcr_tgt_t;
    typedef logic [`DROP_CNT_BITS-1:0] drop_cnt_t;

    // Incoming cluster write bus
    typedef struct packed {
        logic      valid;
        dcr_addr_t addr;
        dcr_data_t data;
    } dcr_write_t;

    // One target's slice, index local to its window
    typedef struct packed {
        logic      valid;
        dcr_idx_t  idx;
        dcr_data_t data;
    } dcr_local_write_t;

    typedef struct packed {
        dcr_local_write_t base;
        dcr_local_write_t raster;
        dcr_local_write_t tex;
        logic             miss;
    } dcr_routed_t;

    typedef struct packed {
        logic      valid;
        dcr_tgt_t  tgt;
        dcr_idx_t  idx;
    } dcr_read_req_t;

    typedef struct packed {
        logic      valid;
        dcr_data_t data;
    } dcr_read_rsp_t;

endpackage

`default_nettype wire

// ==== logic/dcr_router.sv ====
/*
 * DCR router
 * Splits the cluster write bus by address window into base, raster and
 * texture local writes, and flags valid writes that hit no window.
 */

`timescale 1ns/1ns
`default_nettype none

`include "cluster_defs.svh"

module dcr_router (
    input  wire cluster_pkg::dcr_write_t dcr_write,
    output cluster_pkg::dcr_routed_t     routed
);

    function automatic logic in_window(
        input cluster_pkg::dcr_addr_t addr,
        input cluster_pkg::dcr_addr_t lo,
        input cluster_pkg::dcr_addr_t hi
    );
        return (addr >= lo) && (addr < hi);
    endfunction

    logic hit_base;
    logic hit_raster;
    logic hit_tex;

    assign hit_base   = in_window(dcr_write.addr, `DCR_BASE_BEGIN, `DCR_BASE_END);
    assign hit_raster = in_window(dcr_write.addr, `DCR_RASTER_BEGIN, `DCR_RASTER_END);
    assign hit_tex    = in_window(dcr_write.addr, `DCR_TEX_BEGIN, `DCR_TEX_END);

    //**************************************************************************
    // Per-target slices
    //**************************************************************************

    always_comb begin
        routed.base.valid   = dcr_write.valid && hit_base;
        routed.base.idx     = cluster_pkg::dcr_idx_t'(dcr_write.addr - `DCR_BASE_BEGIN);
        routed.base.data    = dcr_write.data;

        routed.raster.valid = dcr_write.valid && hit_raster;
        routed.raster.idx   = cluster_pkg::dcr_idx_t'(dcr_write.addr - `DCR_RASTER_BEGIN);
        routed.raster.data  = dcr_write.data;

        routed.tex.valid    = dcr_write.valid && hit_tex;
        routed.tex.idx      = cluster_pkg::dcr_idx_t'(dcr_write.addr - `DCR_TEX_BEGIN);
        routed.tex.data     = dcr_write.data;

        // Valid write outside every window
        routed.miss = dcr_write.valid && !(hit_base || hit_raster || hit_tex);
    end

    // Windows must never overlap
    always_comb begin
        assert ($onehot0({routed.base.valid, routed.raster.valid,
                          routed.tex.valid, routed.miss}))
            else $error("dcr_router: write routed to more than one target");
    end

endmodule

`default_nettype wire

// ==== logic/dcr_stage.sv ====
/*
 * DCR retiming stage
 * Registers the routed write bus for one cycle and keeps a saturating
 * count of writes that hit no window.
 */

`timescale 1ns/1ns
`default_nettype none

module dcr_stage (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire cluster_pkg::dcr_routed_t routed_in,
    output cluster_pkg::dcr_routed_t     routed_out,
    output cluster_pkg::drop_cnt_t       drop_count
);

    // Payload follows the input, strobes cleared on reset
    always_ff @(posedge clk) begin
        routed_out <= routed_in;
        if (!rst_n) begin
            routed_out.base.valid   <= 1'b0;
            routed_out.raster.valid <= 1'b0;
            routed_out.tex.valid    <= 1'b0;
            routed_out.miss         <= 1'b0;
        end
    end

    //**************************************************************************
    // Dropped write counter
    //**************************************************************************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            drop_count <= '0;
        end else if (routed_out.miss && (drop_count != '1)) begin
            drop_count <= drop_count + 1'b1;
        end
    end

    // A miss seen here must not also target a unit
    a_miss_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n)
        routed_out.miss |-> !(routed_out.base.valid || routed_out.raster.valid ||
                              routed_out.tex.valid)
    ) else $error("dcr_stage: miss with a target write");

endmodule

`default_nettype wire

// ==== logic/dcr_state_file.sv ====
/*
 * DCR state file
 * Registers of the base, raster and texture targets, written from the
 * retimed local writes, with a read port registered by one cycle.
 */

`timescale 1ns/1ns
`default_nettype none

`include "cluster_defs.svh"

module dcr_state_file (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire cluster_pkg::dcr_routed_t   wr,
    input  wire cluster_pkg::dcr_read_req_t rd_req,
    output cluster_pkg::dcr_read_rsp_t     rd_rsp
);

    localparam int BASE_REGS   = `DCR_BASE_END - `DCR_BASE_BEGIN;
    localparam int RASTER_REGS = `DCR_RASTER_END - `DCR_RASTER_BEGIN;
    localparam int TEX_REGS    = `DCR_TEX_END - `DCR_TEX_BEGIN;
    localparam int RASTER_IDX  = $clog2(RASTER_REGS);
    localparam int TEX_IDX     = $clog2(TEX_REGS);

    cluster_pkg::dcr_data_t base_regs   [BASE_REGS];
    cluster_pkg::dcr_data_t raster_regs [RASTER_REGS];
    cluster_pkg::dcr_data_t tex_regs    [TEX_REGS];
    cluster_pkg::dcr_data_t rd_data;

    //**************************************************************************
    // Register write
    //**************************************************************************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < BASE_REGS; i++) begin
                base_regs[i] <= '0;
            end
            for (int i = 0; i < RASTER_REGS; i++) begin
                raster_regs[i] <= '0;
            end
            for (int i = 0; i < TEX_REGS; i++) begin
                tex_regs[i] <= '0;
            end
        end else begin
            if (wr.base.valid) begin
                base_regs[wr.base.idx] <= wr.base.data;
            end
            if (wr.raster.valid) begin
                raster_regs[wr.raster.idx[RASTER_IDX-1:0]] <= wr.raster.data;
            end
            if (wr.tex.valid) begin
                tex_regs[wr.tex.idx[TEX_IDX-1:0]] <= wr.tex.data;
            end
        end
    end

    //**************************************************************************
    // Read port
    //**************************************************************************

    // Unmapped target or index reads as zero
    always_comb begin
        rd_data = '0;
        case (rd_req.tgt)
            cluster_pkg::dcr_tgt_t'(`DCR_TGT_BASE): begin
                rd_data = base_regs[rd_req.idx];
            end
            cluster_pkg::dcr_tgt_t'(`DCR_TGT_RASTER): begin
                if (rd_req.idx < RASTER_REGS) begin
                    rd_data = raster_regs[rd_req.idx[RASTER_IDX-1:0]];
                end
            end
            cluster_pkg::dcr_tgt_t'(`DCR_TGT_TEX): begin
                if (rd_req.idx < TEX_REGS) begin
                    rd_data = tex_regs[rd_req.idx[TEX_IDX-1:0]];
                end
            end
            default: rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        rd_rsp.data <= rd_data;
        if (!rst_n) begin
            rd_rsp.valid <= 1'b0;
        end else begin
            rd_rsp.valid <= rd_req.valid;
        end
    end

    // Router offsets must fit the smaller windows
    a_idx_in_window: assert property (
        @(posedge clk) disable iff (!rst_n)
        (wr.raster.valid -> (wr.raster.idx < RASTER_REGS)) &&
        (wr.tex.valid -> (wr.tex.idx < TEX_REGS))
    ) else $error("dcr_state_file: local write index out of window");

endmodule

`default_nettype wire

// ==== logic/cluster_dcr.sv ====
/*
 * Cluster DCR path top level
 * Routes the DCR write bus by window, retimes the slices one cycle and
 * stores them in the target state file, which also serves reads.
 */

`timescale 1ns/1ns
`default_nettype none

module cluster_dcr (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire cluster_pkg::dcr_write_t    dcr_write,
    input  wire cluster_pkg::dcr_read_req_t rd_req,
    output wire cluster_pkg::dcr_read_rsp_t rd_rsp,
    output wire cluster_pkg::drop_cnt_t     drop_count
);

    // Decoded slices, combinational
    cluster_pkg::dcr_routed_t routed;

    // Slices after the retiming stage
    cluster_pkg::dcr_routed_t routed_q;

    //**************************************************************************
    // Address decode
    //**************************************************************************

    dcr_router router_i (
        .dcr_write  (dcr_write),
        .routed     (routed)
    );

    //**************************************************************************
    // One cycle buffer and miss count
    //**************************************************************************

    dcr_stage stage_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .routed_in  (routed),
        .routed_out (routed_q),
        .drop_count (drop_count)
    );

    //**************************************************************************
    // Target registers
    //**************************************************************************

    dcr_state_file state_file_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr         (routed_q),
        .rd_req     (rd_req),
        .rd_rsp     (rd_rsp)
    );

endmodule

`default_nettype wire

// ==== test/cluster_dcr_tb.sv ====
/*
 * Cluster DCR path testbench
 * Random window writes, dropped writes and reads from a fixed seed,
 * checked against a per-target register model.
 */

`timescale 1ns/1ns
`default_nettype none

`include "cluster_defs.svh"

module cluster_dcr_tb;

    localparam int BASE_REGS    = `DCR_BASE_END - `DCR_BASE_BEGIN;
    localparam int RASTER_REGS  = `DCR_RASTER_END - `DCR_RASTER_BEGIN;
    localparam int TEX_REGS     = `DCR_TEX_END - `DCR_TEX_BEGIN;
    localparam int RESP_TIMEOUT = 10;

    logic                             clk;
    logic                             rst_n;
    cluster_pkg::dcr_write_t          dcr_write;
    cluster_pkg::dcr_read_req_t       rd_req;
    wire cluster_pkg::dcr_read_rsp_t  rd_rsp;
    wire cluster_pkg::drop_cnt_t      drop_count;

    // Reference register model
    cluster_pkg::dcr_data_t base_model   [BASE_REGS];
    cluster_pkg::dcr_data_t raster_model [RASTER_REGS];
    cluster_pkg::dcr_data_t tex_model    [TEX_REGS];
    cluster_pkg::drop_cnt_t exp_drops;

    // Expected data of reads still in flight
    cluster_pkg::dcr_data_t pending_rsp [$];

    cluster_dcr cluster_dcr_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .dcr_write  (dcr_write),
        .rd_req     (rd_req),
        .rd_rsp     (rd_rsp),
        .drop_count (drop_count)
    );

    always #2 clk = ~clk;

    //**************************************************************************
    // Failure reporting and compare tasks
    //**************************************************************************

    task automatic stop_on_failure();
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_data(
        input string                  name,
        input cluster_pkg::dcr_data_t got,
        input cluster_pkg::dcr_data_t exp
    );
        if (got !== exp) begin
            $display("** Error %s: got 0x%08h expected 0x%08h", name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_drops(
        input cluster_pkg::drop_cnt_t got,
        input cluster_pkg::drop_cnt_t exp
    );
        if (got !== exp) begin
            $display("** Error drop_count: got 0x%04h expected 0x%04h", got, exp);
            stop_on_failure();
        end
    endtask

    //**************************************************************************
    // Reference model
    //**************************************************************************

    function automatic logic window_hit(
        input cluster_pkg::dcr_addr_t addr,
        input cluster_pkg::dcr_addr_t lo,
        input cluster_pkg::dcr_addr_t hi
    );
        return (addr >= lo) && (addr < hi);
    endfunction

    function automatic logic any_window_hit(input cluster_pkg::dcr_addr_t addr);
        return window_hit(addr, `DCR_BASE_BEGIN, `DCR_BASE_END) ||
               window_hit(addr, `DCR_RASTER_BEGIN, `DCR_RASTER_END) ||
               window_hit(addr, `DCR_TEX_BEGIN, `DCR_TEX_END);
    endfunction

    task automatic model_write(
        input cluster_pkg::dcr_addr_t addr,
        input cluster_pkg::dcr_data_t data
    );
        if (window_hit(addr, `DCR_BASE_BEGIN, `DCR_BASE_END)) begin
            base_model[addr - `DCR_BASE_BEGIN] = data;
        end else if (window_hit(addr, `DCR_RASTER_BEGIN, `DCR_RASTER_END)) begin
            raster_model[addr - `DCR_RASTER_BEGIN] = data;
        end else if (window_hit(addr, `DCR_TEX_BEGIN, `DCR_TEX_END)) begin
            tex_model[addr - `DCR_TEX_BEGIN] = data;
        end else if (exp_drops != '1) begin
            exp_drops = exp_drops + 1'b1;
        end
    endtask

    // Unmapped target or index reads as zero
    function automatic cluster_pkg::dcr_data_t expected_read(
        input cluster_pkg::dcr_tgt_t tgt,
        input cluster_pkg::dcr_idx_t idx
    );
        case (tgt)
            `DCR_TGT_BASE:   return (idx < BASE_REGS) ? base_model[idx] : '0;
            `DCR_TGT_RASTER: return (idx < RASTER_REGS) ? raster_model[idx] : '0;
            `DCR_TGT_TEX:    return (idx < TEX_REGS) ? tex_model[idx] : '0;
            default:         return '0;
        endcase
    endfunction

    //**************************************************************************
    // Stimulus
    //**************************************************************************

    function automatic cluster_pkg::dcr_addr_t random_window_addr();
        case ($urandom_range(0, 2))
            0:       return `DCR_BASE_BEGIN + $urandom_range(0, BASE_REGS - 1);
            1:       return `DCR_RASTER_BEGIN + $urandom_range(0, RASTER_REGS - 1);
            default: return `DCR_TEX_BEGIN + $urandom_range(0, TEX_REGS - 1);
        endcase
    endfunction

    // Often just outside a window edge, otherwise anywhere
    function automatic cluster_pkg::dcr_addr_t random_miss_addr();
        cluster_pkg::dcr_addr_t addr;
        case ($urandom_range(0, 11))
            0:       addr = `DCR_BASE_BEGIN - 1;
            1:       addr = `DCR_BASE_END;
            2:       addr = `DCR_RASTER_BEGIN - 1;
            3:       addr = `DCR_RASTER_END;
            4:       addr = `DCR_TEX_BEGIN - 1;
            5:       addr = `DCR_TEX_END;
            default: addr = cluster_pkg::dcr_addr_t'($urandom);
        endcase
        // Flipping the top bit moves any window hit far above every window
        if (any_window_hit(addr)) begin
            addr = addr ^ 12'h800;
        end
        return addr;
    endfunction

    task automatic write_bus(
        input logic                   valid,
        input cluster_pkg::dcr_addr_t addr,
        input cluster_pkg::dcr_data_t data
    );
        @(negedge clk);
        dcr_write.valid = valid;
        dcr_write.addr  = addr;
        dcr_write.data  = data;
        if (valid) begin
            model_write(addr, data);
        end
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            dcr_write.valid = 1'b0;
            rd_req.valid    = 1'b0;
        end
    endtask

    task automatic read_and_check(
        input cluster_pkg::dcr_tgt_t tgt,
        input cluster_pkg::dcr_idx_t idx
    );
        cluster_pkg::dcr_data_t exp;
        int                     waited;
        exp = expected_read(tgt, idx);
        @(negedge clk);
        dcr_write.valid = 1'b0;
        rd_req.valid    = 1'b1;
        rd_req.tgt      = tgt;
        rd_req.idx      = idx;
        waited = 0;
        do begin
            @(negedge clk);
            rd_req.valid = 1'b0;
            waited++;
        end while (!rd_rsp.valid && (waited < RESP_TIMEOUT));
        if (!rd_rsp.valid) begin
            $display("Timeout: no read response within %0d cycles", RESP_TIMEOUT);
            stop_on_failure();
        end
        check_data($sformatf("rd_rsp.data[tgt %0d idx %0d]", tgt, idx), rd_rsp.data, exp);
    endtask

    // Covers every target code and index, unmapped ones included
    task automatic read_all();
        for (int t = 0; t < 4; t++) begin
            for (int i = 0; i < 8; i++) begin
                read_and_check(cluster_pkg::dcr_tgt_t'(t), cluster_pkg::dcr_idx_t'(i));
            end
        end
    endtask

    task automatic check_drop_count();
        idle_cycles(3);
        check_drops(drop_count, exp_drops);
    endtask

    task automatic check_next_rsp();
        if (!rd_rsp.valid) begin
            $display("Read response missing in the cycle after its request");
            stop_on_failure();
        end
        check_data("rd_rsp.data", rd_rsp.data, pending_rsp.pop_front());
    endtask

    // One request per cycle, each answer due exactly one cycle later
    task automatic back_to_back_reads(input int n);
        cluster_pkg::dcr_tgt_t tgt;
        cluster_pkg::dcr_idx_t idx;
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            if (i > 0) begin
                check_next_rsp();
            end
            tgt = cluster_pkg::dcr_tgt_t'($urandom_range(0, 3));
            idx = cluster_pkg::dcr_idx_t'($urandom_range(0, 7));
            pending_rsp.push_back(expected_read(tgt, idx));
            rd_req.valid = 1'b1;
            rd_req.tgt   = tgt;
            rd_req.idx   = idx;
        end
        @(negedge clk);
        rd_req.valid = 1'b0;
        check_next_rsp();
        @(negedge clk);
        if (rd_rsp.valid) begin
            $display("Read response still valid with no request pending");
            stop_on_failure();
        end
    endtask

    //**************************************************************************
    // Test sequence
    //**************************************************************************

    initial begin
        int seed_ret;
        clk       = 1'b0;
        rst_n     = 1'b0;
        dcr_write = '0;
        rd_req    = '0;
        seed_ret  = $urandom(60);
        foreach (base_model[i]) base_model[i] = '0;
        foreach (raster_model[i]) raster_model[i] = '0;
        foreach (tex_model[i]) tex_model[i] = '0;
        exp_drops = '0;

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Reset state
        read_all();
        check_drop_count();

        // Window routing
        repeat (40) write_bus(1'b1, random_window_addr(), $urandom);
        idle_cycles(2);
        read_all();

        // Dropped writes leave registers alone
        repeat (20) write_bus(1'b1, random_miss_addr(), $urandom);
        check_drop_count();
        read_all();

        // Long mix, then reads on consecutive cycles
        for (int i = 0; i < 200; i++) begin
            if ($urandom_range(0, 3) == 0) begin
                write_bus(1'b1, random_miss_addr(), $urandom);
            end else begin
                write_bus(1'b1, random_window_addr(), $urandom);
            end
        end
        idle_cycles(2);
        back_to_back_reads(64);
        check_drop_count();

        // Strobes low with random payload, window addresses included
        repeat (15) write_bus(1'b0, random_window_addr(), $urandom);
        repeat (15) write_bus(1'b0, cluster_pkg::dcr_addr_t'($urandom), $urandom);
        check_drop_count();
        read_all();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+logic
logic/cluster_pkg.sv
logic/dcr_router.sv
logic/dcr_stage.sv
logic/dcr_state_file.sv
logic/cluster_dcr.sv
test/cluster_dcr_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the cluster DCR testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module cluster_dcr_tb -Mdir obj_dir -o sim > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/sim > sim.log 2>&1

grep -q "TESTBENCH FAILED" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "Simulation ended early, see sim.log"; exit 1; }
echo "Simulation finished without errors"
